// File: ps2_kbd.f
verilog/ps2_kbd_pkg.sv
verilog/ps2_frame_rx.sv
verilog/key_event_filter.sv
verilog/scan_code_fifo.sv
verilog/seg_display.sv
verilog/ps2_kbd_top.sv
verification/tb_clock_gen.sv
verification/ps2_kbd_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ps2_kbd_tb
LOG       ?= sim.log

FILELIST := ps2_kbd.f
SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a listed source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@! grep -q "Simulation failed" $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/ps2_kbd_tb.sv
module ps2_kbd_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ps2_kbd_pkg::*;

    localparam int FRAME_TIMEOUT = 200;
    localparam int HALF = 6;
    localparam int READY_TIMEOUT = 50;
    localparam seg_t GLYPHS [16] = '{7'h01, 7'h4F, 7'h12, 7'h06, 7'h4C, 7'h24, 7'h20, 7'h0F,
                                     7'h00, 7'h04, 7'h08, 7'h60, 7'h31, 7'h42, 7'h30, 7'h38};

    logic       clk;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       next_n;
    scan_code_t data;
    logic       ready;
    logic       overflow;
    seg_t       seg0;
    seg_t       seg1;
    seg_t       seg2;
    seg_t       seg3;

    // Reference model state
    scan_code_t  exp_q[$];
    logic        exp_held;
    logic        exp_release;
    logic        exp_ovf;
    logic        exp_wrapped;
    int          exp_count;

    logic [31:0] rng_state;
    logic [31:0] r;
    scan_code_t  code;
    scan_code_t  last_code;
    string       cur_test;
    int          err_count;
    int          test_err_start;
    int          pass_tests;
    int          fail_tests;

    tb_clock_gen #(.PERIOD_NS(100)) clk_gen0 (.clk(clk));

    ps2_kbd_top #(
        .FIFO_DEPTH   (8),
        .FRAME_TIMEOUT(FRAME_TIMEOUT)
    ) dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ps2_clk (ps2_clk),
        .ps2_data(ps2_data),
        .next_n  (next_n),
        .data    (data),
        .ready   (ready),
        .overflow(overflow),
        .seg0    (seg0),
        .seg1    (seg1),
        .seg2    (seg2),
        .seg3    (seg3)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic scan_code_t random_make();
        logic [31:0] v;
        v = next_rand();
        while (v[7:0] == BREAK_PREFIX) begin
            v = next_rand();
        end
        return v[7:0];
    endfunction

    function automatic seg_t glyph_of(input logic [3:0] v);
        return GLYPHS[v];
    endfunction

    // Reads the count back from the two decimal digits, 7F when a digit is not a glyph
    function automatic key_count_t shown_count();
        int units;
        int tens;
        units = -1;
        tens  = -1;
        for (int i = 0; i < 10; i++) begin
            if (GLYPHS[i] === seg2) units = i;
            if (GLYPHS[i] === seg3) tens = i;
        end
        if (units < 0 || tens < 0) return 7'h7F;
        return key_count_t'(tens * 10 + units);
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic check_code(input string what, input scan_code_t exp, input scan_code_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_count(input string what, input key_count_t exp, input key_count_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %0d actual %0d", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_seg(input string what, input seg_t exp, input seg_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %b actual %b", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_state();
        scan_code_t head;
        check_flag("ready", exp_q.size() > 0, ready);
        check_flag("overflow", exp_ovf, overflow);
        if (exp_q.size() > 0) begin
            head = exp_q[0];
            check_code("data", head, data);
            check_seg("seg0", glyph_of(head[3:0]), seg0);
            check_seg("seg1", glyph_of(head[7:4]), seg1);
        end else begin
            check_seg("seg0", 7'h7F, seg0);
            check_seg("seg1", 7'h7F, seg1);
        end
        check_count("press count", key_count_t'(exp_count), shown_count());
    endtask

    // Start bit, eight data bits LSB first, odd parity, stop bit
    task automatic send_frame(input scan_code_t c, input logic bad_parity,
                              input logic bad_stop, input int nbits);
        logic [10:0] frame;
        frame = {~bad_stop, (~^c) ^ bad_parity, c, 1'b0};
        for (int i = 0; i < nbits; i++) begin
            ps2_data = frame[i];
            step(HALF);
            ps2_clk = 1'b0;
            step(HALF);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        step(HALF);
    endtask

    task automatic apply_code(input scan_code_t c);
        if (c == BREAK_PREFIX) begin
            exp_release = 1'b1;
        end else if (exp_release) begin
            exp_release = 1'b0;
            exp_held    = 1'b0;
        end else begin
            if (exp_q.size() < 8) exp_q.push_back(c);
            else exp_ovf = 1'b1;
            if (!exp_held) begin
                exp_held = 1'b1;
                if (exp_count == 99) exp_wrapped = 1'b1;
                exp_count = (exp_count + 1) % 100;
            end
        end
    endtask

    task automatic send_good(input scan_code_t c);
        send_frame(c, 1'b0, 1'b0, 11);
        apply_code(c);
        check_state();
    endtask

    task automatic pop_check();
        int waited;
        waited = 0;
        while (ready !== 1'b1 && waited < READY_TIMEOUT) begin
            step(1);
            waited++;
        end
        if (ready !== 1'b1) begin
            $display("%s: timed out waiting for ready before a pop", cur_test);
            err_count++;
        end
        check_state();
        next_n = 1'b0;
        step(1);
        next_n = 1'b1;
        if (exp_q.size() > 0) void'(exp_q.pop_front());
        check_state();
    endtask

    task automatic drain();
        while (exp_q.size() > 0) begin
            pop_check();
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_start = err_count;
    endtask

    task automatic finish_test();
        if (err_count == test_err_start) begin
            $display("PASS %s", cur_test);
            pass_tests++;
        end else begin
            $display("FAIL %s with %0d errors", cur_test, err_count - test_err_start);
            fail_tests++;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        next_n      = 1'b1;
        rng_state   = 32'h649ba35d;
        exp_held    = 1'b0;
        exp_release = 1'b0;
        exp_ovf     = 1'b0;
        exp_wrapped = 1'b0;
        exp_count   = 0;
        err_count   = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        step(2);

        start_test("reset_and_makes");
        check_state();
        for (int i = 0; i < 30; i++) begin
            send_good(random_make());
            pop_check();
        end
        finish_test();

        // Breaks are likelier than repeats so the count climbs past 99 in reasonable time
        start_test("mixed_events");
        last_code = 8'h1C;
        for (int n = 0; n < 1000 && !(exp_wrapped && n >= 40); n++) begin
            r = next_rand();
            if (exp_held && r[1:0] != 2'd0) begin
                send_good(BREAK_PREFIX);
                send_good(last_code);
            end else begin
                if (!exp_held) last_code = random_make();
                send_good(last_code);
            end
            drain();
        end
        if (!exp_wrapped) begin
            $display("%s: the press count never wrapped past 99", cur_test);
            err_count++;
        end
        finish_test();

        start_test("bad_frames");
        last_code = random_make();
        send_good(last_code);
        // With the key released a wrongly accepted frame would also move the count
        send_good(BREAK_PREFIX);
        send_good(last_code);
        code = random_make();
        send_frame(code, 1'b1, 1'b0, 11);
        check_state();
        send_frame(code, 1'b0, 1'b1, 11);
        check_state();
        send_good(code);
        drain();
        finish_test();

        start_test("frame_timeout");
        send_frame(random_make(), 1'b0, 1'b0, 5);
        step(FRAME_TIMEOUT + 50);
        check_state();
        send_good(random_make());
        drain();
        finish_test();

        start_test("overflow");
        for (int i = 0; i < 9; i++) begin
            send_good(random_make());
        end
        drain();
        finish_test();

        $display("Tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: verilog/ps2_kbd_top.sv
module ps2_kbd_top #(
    parameter int FIFO_DEPTH    = 8,
    parameter int FRAME_TIMEOUT = 2000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ps2_clk,
    input  logic                    ps2_data,
    input  logic                    next_n,
    output ps2_kbd_pkg::scan_code_t data,
    output logic                    ready,
    output logic                    overflow,
    output ps2_kbd_pkg::seg_t       seg0,
    output ps2_kbd_pkg::seg_t       seg1,
    output ps2_kbd_pkg::seg_t       seg2,
    output ps2_kbd_pkg::seg_t       seg3
);
    import ps2_kbd_pkg::*;

    scan_code_t code;
    logic       code_valid;
    logic       push;
    scan_code_t push_code;
    key_count_t press_count;

    ps2_frame_rx #(
        .FRAME_TIMEOUT(FRAME_TIMEOUT)
    ) rx0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .code      (code),
        .code_valid(code_valid)
    );

    key_event_filter filter0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .code       (code),
        .code_valid (code_valid),
        .push       (push),
        .push_code  (push_code),
        .press_count(press_count)
    );

    scan_code_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .push_code(push_code),
        .next_n   (next_n),
        .data     (data),
        .ready    (ready),
        .overflow (overflow)
    );

    seg_display disp0 (
        .data       (data),
        .ready      (ready),
        .press_count(press_count),
        .seg0       (seg0),
        .seg1       (seg1),
        .seg2       (seg2),
        .seg3       (seg3)
    );

endmodule

// File: verilog/seg_display.sv
module seg_display (
    input  ps2_kbd_pkg::scan_code_t data,
    input  logic                    ready,
    input  ps2_kbd_pkg::key_count_t press_count,
    output ps2_kbd_pkg::seg_t       seg0,
    output ps2_kbd_pkg::seg_t       seg1,
    output ps2_kbd_pkg::seg_t       seg2,
    output ps2_kbd_pkg::seg_t       seg3
);
    import ps2_kbd_pkg::*;

    localparam seg_t SEG_BLANK = 7'h7F;

    key_count_t tens;
    key_count_t units;

    function automatic seg_t hex_glyph(input logic [3:0] value);
        seg_t glyph;
        case (value)
            4'h0: glyph = 7'h01;
            4'h1: glyph = 7'h4F;
            4'h2: glyph = 7'h12;
            4'h3: glyph = 7'h06;
            4'h4: glyph = 7'h4C;
            4'h5: glyph = 7'h24;
            4'h6: glyph = 7'h20;
            4'h7: glyph = 7'h0F;
            4'h8: glyph = 7'h00;
            4'h9: glyph = 7'h04;
            4'hA: glyph = 7'h08;
            4'hB: glyph = 7'h60;
            4'hC: glyph = 7'h31;
            4'hD: glyph = 7'h42;
            4'hE: glyph = 7'h30;
            default: glyph = 7'h38;
        endcase
        return glyph;
    endfunction

    // Head code in hex, blanked while the FIFO is empty
    assign seg0 = ready ? hex_glyph(data[3:0]) : SEG_BLANK;
    assign seg1 = ready ? hex_glyph(data[7:4]) : SEG_BLANK;

    // Count never passes 99, so both decimal digits fit in a nibble
    assign tens  = press_count / 7'd10;
    assign units = press_count - tens * 7'd10;

    assign seg2 = hex_glyph(units[3:0]);
    assign seg3 = hex_glyph(tens[3:0]);

endmodule

// File: verilog/scan_code_fifo.sv
module scan_code_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  ps2_kbd_pkg::scan_code_t push_code,
    input  logic                    next_n,
    output ps2_kbd_pkg::scan_code_t data,
    output logic                    ready,
    output logic                    overflow
);
    import ps2_kbd_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    scan_code_t  mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] occupancy;
    logic        empty;
    logic        full;
    logic        pop;
    logic        do_push;

    // The extra pointer bit lets a full buffer be told apart from an empty one
    assign occupancy = wr_ptr - rd_ptr;
    assign empty     = (occupancy == '0);
    assign full      = (occupancy == (AW + 1)'(FIFO_DEPTH));

    assign pop     = !next_n && !empty;
    assign do_push = push && (!full || pop);

    assign data  = mem[rd_ptr[AW-1:0]];
    assign ready = !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_code;
        end
    end

    a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= (AW + 1)'(FIFO_DEPTH));

endmodule

// File: verilog/key_event_filter.sv
module key_event_filter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ps2_kbd_pkg::scan_code_t code,
    input  logic                    code_valid,
    output logic                    push,
    output ps2_kbd_pkg::scan_code_t push_code,
    output ps2_kbd_pkg::key_count_t press_count
);
    import ps2_kbd_pkg::*;

    localparam key_count_t COUNT_MAX = 7'd99;

    logic release_pending;
    logic held;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            release_pending <= 1'b0;
            held            <= 1'b0;
            push            <= 1'b0;
            press_count     <= '0;
        end else begin
            push <= 1'b0;
            if (code_valid) begin
                if (code == BREAK_PREFIX) begin
                    release_pending <= 1'b1;
                end else if (release_pending) begin
                    // The released key's code is swallowed
                    release_pending <= 1'b0;
                    held            <= 1'b0;
                end else begin
                    push <= 1'b1;
                    // Typematic repeats are stored but only a fresh press is counted
                    if (!held) begin
                        held <= 1'b1;
                        if (press_count == COUNT_MAX) begin
                            press_count <= '0;
                        end else begin
                            press_count <= press_count + 7'd1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (code_valid) begin
            push_code <= code;
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        press_count <= COUNT_MAX);

endmodule

// File: verilog/ps2_frame_rx.sv
module ps2_frame_rx #(
    parameter int FRAME_TIMEOUT = 2000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ps2_clk,
    input  logic                    ps2_data,
    output ps2_kbd_pkg::scan_code_t code,
    output logic                    code_valid
);
    import ps2_kbd_pkg::*;

    localparam int TW = $clog2(FRAME_TIMEOUT + 1);
    localparam logic [TW-1:0] TIMEOUT_LAST = TW'(FRAME_TIMEOUT - 1);

    logic [1:0]    ps2_clk_sync;
    logic [1:0]    ps2_data_sync;
    logic          ps2_clk_prev;
    logic          falling;
    rx_state_t     state;
    logic [2:0]    bit_cnt;
    logic [TW-1:0] idle_cnt;
    logic          start_bit;
    logic          parity_bit;

    // Both lines idle high, so reset the synchronizers to ones to avoid a false edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ps2_clk_sync  <= 2'b11;
            ps2_data_sync <= 2'b11;
            ps2_clk_prev  <= 1'b1;
        end else begin
            ps2_clk_sync  <= {ps2_clk_sync[0], ps2_clk};
            ps2_data_sync <= {ps2_data_sync[0], ps2_data};
            ps2_clk_prev  <= ps2_clk_sync[1];
        end
    end

    assign falling = ps2_clk_prev & ~ps2_clk_sync[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            bit_cnt    <= 3'd0;
            idle_cnt   <= '0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (falling) begin
                idle_cnt <= '0;
                case (state)
                    RX_IDLE: begin
                        bit_cnt <= 3'd0;
                        state   <= RX_DATA;
                    end
                    RX_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        state <= RX_STOP;
                    end
                    RX_STOP: begin
                        // Odd parity means the nine bits hold an odd number of ones
                        if (ps2_data_sync[1] && !start_bit && (^{code, parity_bit})) begin
                            code_valid <= 1'b1;
                        end
                        state <= RX_IDLE;
                    end
                    default: begin
                        state <= RX_IDLE;
                    end
                endcase
            end else if (state != RX_IDLE) begin
                // A stalled frame is abandoned so the next start bit is seen cleanly
                if (idle_cnt == TIMEOUT_LAST) begin
                    state    <= RX_IDLE;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (falling) begin
            case (state)
                RX_IDLE:   start_bit  <= ps2_data_sync[1];
                RX_DATA:   code       <= {ps2_data_sync[1], code[7:1]};
                RX_PARITY: parity_bit <= ps2_data_sync[1];
                default:   ;
            endcase
        end
    end

    // Frames are at least eleven PS/2 edges apart, so a valid pulse is always isolated
    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        code_valid |=> !code_valid);

endmodule

// File: verilog/ps2_kbd_pkg.sv
package ps2_kbd_pkg;

    // One data byte as it arrives from the keyboard
    typedef logic [7:0] scan_code_t;

    // Active-low segment pattern, bit 6 is segment a and bit 0 is segment g
    typedef logic [6:0] seg_t;

    // Press counter, kept in the range 0 to 99
    typedef logic [6:0] key_count_t;

    // Prefix that announces a key release
    localparam scan_code_t BREAK_PREFIX = 8'hF0;

    // Frame receiver states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

endpackage
